//--- common/periph_pkg.sv
// ----------------------------------------------------------------------
// Peripheral domain definitions
// Bus structs, address map, register offsets and interrupt layout
// ----------------------------------------------------------------------
package periph_pkg;

  // Request and response of the peripheral bus
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // Decode targets, index 0 is the error subordinate
  typedef enum logic [1:0] {
    PeriphError   = 2'd0,
    PeriphSocCtrl = 2'd1,
    PeriphGpio    = 2'd2,
    PeriphTimer   = 2'd3
  } periph_idx_e;

  localparam int unsigned NumPeriphs = 4;

  // ----------------------------------------------------------------------
  // Address map, 4 KiB per window
  // ----------------------------------------------------------------------
  localparam int unsigned PeriphOffsetWidth = 12;
  localparam logic [31:0] SocCtrlBase       = 32'h0300_0000;
  localparam logic [31:0] GpioBase          = 32'h0300_5000;
  localparam logic [31:0] TimerBase         = 32'h0300_A000;
  localparam logic [31:0] ErrRspData        = 32'hBADC_AB1E;

  // SoC control
  localparam logic [PeriphOffsetWidth-1:0] RegBootAddr      = 12'h000;
  localparam logic [PeriphOffsetWidth-1:0] RegFetchEn       = 12'h004;
  localparam logic [31:0]                  BootAddrReset    = 32'h1000_0000;

  // GPIO
  localparam logic [PeriphOffsetWidth-1:0] RegGpioDir       = 12'h000;
  localparam logic [PeriphOffsetWidth-1:0] RegGpioOut       = 12'h004;
  localparam logic [PeriphOffsetWidth-1:0] RegGpioIn        = 12'h008;
  localparam logic [PeriphOffsetWidth-1:0] RegGpioIrqEn     = 12'h00C;
  localparam logic [PeriphOffsetWidth-1:0] RegGpioIrqStatus = 12'h010;

  // Timer
  localparam logic [PeriphOffsetWidth-1:0] RegTimerCtrl     = 12'h000;
  localparam logic [PeriphOffsetWidth-1:0] RegTimerCount    = 12'h004;
  localparam logic [PeriphOffsetWidth-1:0] RegTimerCmp      = 12'h008;
  localparam logic [PeriphOffsetWidth-1:0] RegTimerStatus   = 12'h00C;

  // Interrupt vector layout
  localparam int unsigned NumExtIrqs = 4;
  localparam int unsigned NumIrqs    = 16;
  localparam int unsigned IrqTimer   = 0;
  localparam int unsigned IrqGpio    = 1;
  localparam int unsigned IrqExtBase = 2;

  // Byte enables widened to one bit per data bit
  function automatic logic [31:0] be_mask(input logic [3:0] be);
    logic [31:0] mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  // New data on enabled bytes, old data elsewhere
  function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] mask;
    mask = be_mask(be);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

endpackage

//--- source/periph_demux.sv
// ----------------------------------------------------------------------
// Peripheral address demux
// Routes the request to one peripheral, returns its response, and
// answers unmapped addresses as the error subordinate
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module periph_demux import periph_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  bus_req_t                  bus_req_i,
  output bus_rsp_t                  bus_rsp_o,

  output bus_req_t [NumPeriphs-1:1] periph_req_o,
  input  bus_rsp_t [NumPeriphs-1:1] periph_rsp_i
);

  periph_idx_e sel_d;
  periph_idx_e sel_q;
  logic        err_valid_q;

  function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base);
    return addr[31:PeriphOffsetWidth] == base[31:PeriphOffsetWidth];
  endfunction

  // ----------------------------------------------------------------------
  // Address decode, anything outside the map goes to the error target
  // ----------------------------------------------------------------------
  always_comb begin
    if (in_window(bus_req_i.addr, SocCtrlBase)) begin
      sel_d = PeriphSocCtrl;
    end else if (in_window(bus_req_i.addr, GpioBase)) begin
      sel_d = PeriphGpio;
    end else if (in_window(bus_req_i.addr, TimerBase)) begin
      sel_d = PeriphTimer;
    end else begin
      sel_d = PeriphError;
    end
  end

  // Request fanout, peripherals only see the window offset
  always_comb begin
    for (int i = 1; i < NumPeriphs; i++) begin
      periph_req_o[i]      = bus_req_i;
      periph_req_o[i].req  = bus_req_i.req && (sel_d == periph_idx_e'(i));
      periph_req_o[i].addr = 32'(bus_req_i.addr[PeriphOffsetWidth-1:0]);
    end
  end

  // Target of the request in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q       <= PeriphError;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= bus_req_i.req && (sel_d == PeriphError);
      if (bus_req_i.req) begin
        sel_q <= sel_d;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response return
  // ----------------------------------------------------------------------
  always_comb begin
    bus_rsp_o = '0;
    if (sel_d == PeriphError) begin
      bus_rsp_o.gnt = bus_req_i.req;
    end else begin
      bus_rsp_o.gnt = periph_rsp_i[sel_d].gnt;
    end

    if (sel_q == PeriphError) begin
      bus_rsp_o.rvalid = err_valid_q;
      bus_rsp_o.rdata  = ErrRspData;
      bus_rsp_o.err    = err_valid_q;
    end else begin
      bus_rsp_o.rvalid = periph_rsp_i[sel_q].rvalid;
      bus_rsp_o.rdata  = periph_rsp_i[sel_q].rdata;
      bus_rsp_o.err    = periph_rsp_i[sel_q].err;
    end
  end

endmodule

//--- soc_ctrl/soc_ctrl_regs.sv
// ----------------------------------------------------------------------
// SoC control registers
// Boot address and fetch enable, the latter ORed with the pin
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module soc_ctrl_regs import periph_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  bus_req_t    bus_req_i,
  output bus_rsp_t    bus_rsp_o,
  input  logic        fetch_en_i,
  output logic [31:0] boot_addr_o,
  output logic        fetch_enable_o
);

  logic [PeriphOffsetWidth-1:0] offset;
  logic                         wr_en;
  logic [31:0]                  boot_addr_q;
  logic                         fetch_en_q;
  logic [31:0]                  rdata_d;
  logic [31:0]                  rdata_q;
  logic                         rvalid_q;

  assign offset = bus_req_i.addr[PeriphOffsetWidth-1:0];
  assign wr_en  = bus_req_i.req & bus_req_i.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= BootAddrReset;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      if (wr_en && offset == RegBootAddr) begin
        boot_addr_q <= be_merge(boot_addr_q, bus_req_i.wdata, bus_req_i.be);
      end
      if (wr_en && offset == RegFetchEn && bus_req_i.be[0]) begin
        fetch_en_q <= bus_req_i.wdata[0];
      end
    end
  end

  // Read value before the write edge
  always_comb begin
    case (offset)
      RegBootAddr: rdata_d = boot_addr_q;
      RegFetchEn:  rdata_d = {31'b0, fetch_en_q};
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= bus_req_i.we ? '0 : rdata_d;
    end
  end

  assign bus_rsp_o = '{gnt: bus_req_i.req, rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

//--- gpio/gpio_ctrl.sv
// ----------------------------------------------------------------------
// GPIO controller
// Direction and output registers, two-flop input synchronizer and a
// rising edge interrupt with write-one-to-clear status
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module gpio_ctrl import periph_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  bus_req_t             bus_req_i,
  output bus_rsp_t             bus_rsp_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 irq_o
);

  logic [PeriphOffsetWidth-1:0] offset;
  logic                         wr_en;
  logic [GpioCount-1:0]         dir_q, out_q, irq_en_q, status_q;
  logic [GpioCount-1:0]         sync1_q, sync2_q, prev_q;
  logic [GpioCount-1:0]         rise, clr;
  logic [31:0]                  rdata_d;
  logic [31:0]                  rdata_q;
  logic                         rvalid_q;

  assign offset = bus_req_i.addr[PeriphOffsetWidth-1:0];
  assign wr_en  = bus_req_i.req & bus_req_i.we;

  // Enabled rising edges of the synchronized inputs
  assign rise = sync2_q & ~prev_q & irq_en_q;

  // Bits written with one on the status register
  assign clr = (wr_en && offset == RegGpioIrqStatus) ?
               GpioCount'(bus_req_i.wdata & be_mask(bus_req_i.be)) : '0;

  // ----------------------------------------------------------------------
  // Registers and synchronizer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      rvalid_q <= bus_req_i.req;
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~clr) | rise;
      if (wr_en && offset == RegGpioDir) begin
        dir_q <= GpioCount'(be_merge(32'(dir_q), bus_req_i.wdata, bus_req_i.be));
      end
      if (wr_en && offset == RegGpioOut) begin
        out_q <= GpioCount'(be_merge(32'(out_q), bus_req_i.wdata, bus_req_i.be));
      end
      if (wr_en && offset == RegGpioIrqEn) begin
        irq_en_q <= GpioCount'(be_merge(32'(irq_en_q), bus_req_i.wdata, bus_req_i.be));
      end
    end
  end

  always_comb begin
    case (offset)
      RegGpioDir:       rdata_d = 32'(dir_q);
      RegGpioOut:       rdata_d = 32'(out_q);
      RegGpioIn:        rdata_d = 32'(sync2_q);
      RegGpioIrqEn:     rdata_d = 32'(irq_en_q);
      RegGpioIrqStatus: rdata_d = 32'(status_q);
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= bus_req_i.we ? '0 : rdata_d;
    end
  end

  assign bus_rsp_o = '{gnt: bus_req_i.req, rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |status_q;

endmodule

//--- timer/timer_ctrl.sv
// ----------------------------------------------------------------------
// Timer
// Free running counter with compare, wrap on match and sticky IRQ
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module timer_ctrl import periph_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     irq_o
);

  logic [PeriphOffsetWidth-1:0] offset;
  logic                         wr_en;
  logic                         en_q;
  logic [31:0]                  count_q;
  logic [31:0]                  cmp_q;
  logic                         status_q;
  logic                         match;
  logic                         status_clr;
  logic [31:0]                  rdata_d;
  logic [31:0]                  rdata_q;
  logic                         rvalid_q;

  assign offset = bus_req_i.addr[PeriphOffsetWidth-1:0];
  assign wr_en  = bus_req_i.req & bus_req_i.we;
  assign match  = en_q && (count_q == cmp_q);

  assign status_clr = wr_en && offset == RegTimerStatus &&
                      bus_req_i.be[0] && bus_req_i.wdata[0];

  // ----------------------------------------------------------------------
  // Counter and control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q     <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '1;
      status_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
      if (wr_en && offset == RegTimerCtrl && bus_req_i.be[0]) begin
        en_q <= bus_req_i.wdata[0];
      end
      if (wr_en && offset == RegTimerCmp) begin
        cmp_q <= be_merge(cmp_q, bus_req_i.wdata, bus_req_i.be);
      end
      // Software load beats wrap and increment
      if (wr_en && offset == RegTimerCount) begin
        count_q <= be_merge(count_q, bus_req_i.wdata, bus_req_i.be);
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
      if (match) begin
        status_q <= 1'b1;
      end else if (status_clr) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (offset)
      RegTimerCtrl:   rdata_d = {31'b0, en_q};
      RegTimerCount:  rdata_d = count_q;
      RegTimerCmp:    rdata_d = cmp_q;
      RegTimerStatus: rdata_d = {31'b0, status_q};
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= bus_req_i.we ? '0 : rdata_d;
    end
  end

  assign bus_rsp_o = '{gnt: bus_req_i.req, rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};
  assign irq_o     = status_q;

endmodule

//--- source/periph_domain.sv
// ----------------------------------------------------------------------
// Peripheral domain top
// Address demux, SoC control, GPIO and timer, plus interrupt vector
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module periph_domain import periph_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  bus_req_t              bus_req_i,
  output bus_rsp_t              bus_rsp_o,

  input  logic                  fetch_en_i,
  output logic                  fetch_enable_o,
  output logic [31:0]           boot_addr_o,

  input  logic [GpioCount-1:0]  gpio_i,
  output logic [GpioCount-1:0]  gpio_o,
  output logic [GpioCount-1:0]  gpio_out_en_o,
  output logic [GpioCount-1:0]  gpio_in_sync_o,

  input  logic [NumExtIrqs-1:0] ext_irq_i,
  output logic [NumIrqs-1:0]    irq_o
);

  // One bus per peripheral, indexed by the decode target
  bus_req_t [NumPeriphs-1:1] periph_req;
  bus_rsp_t [NumPeriphs-1:1] periph_rsp;

  logic gpio_irq;
  logic timer_irq;

  // ----------------------------------------------------------------------
  // Interrupt vector
  // ----------------------------------------------------------------------
  always_comb begin
    irq_o                           = '0;
    irq_o[IrqTimer]                 = timer_irq;
    irq_o[IrqGpio]                  = gpio_irq;
    irq_o[IrqExtBase +: NumExtIrqs] = ext_irq_i;
  end

  periph_demux i_demux (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .bus_req_i    ( bus_req_i  ),
    .bus_rsp_o    ( bus_rsp_o  ),
    .periph_req_o ( periph_req ),
    .periph_rsp_i ( periph_rsp )
  );

  // Boot address and fetch enable for the core side
  soc_ctrl_regs i_soc_ctrl (
    .clk_i          ( clk_i                     ),
    .arst_n_i       ( arst_n_i                  ),
    .bus_req_i      ( periph_req[PeriphSocCtrl] ),
    .bus_rsp_o      ( periph_rsp[PeriphSocCtrl] ),
    .fetch_en_i     ( fetch_en_i                ),
    .boot_addr_o    ( boot_addr_o               ),
    .fetch_enable_o ( fetch_enable_o            )
  );

  gpio_ctrl #(
    .GpioCount ( GpioCount )
  ) i_gpio (
    .clk_i          ( clk_i                  ),
    .arst_n_i       ( arst_n_i               ),
    .bus_req_i      ( periph_req[PeriphGpio] ),
    .bus_rsp_o      ( periph_rsp[PeriphGpio] ),
    .gpio_i         ( gpio_i                 ),
    .gpio_o         ( gpio_o                 ),
    .gpio_out_en_o  ( gpio_out_en_o          ),
    .gpio_in_sync_o ( gpio_in_sync_o         ),
    .irq_o          ( gpio_irq               )
  );

  timer_ctrl i_timer (
    .clk_i     ( clk_i                   ),
    .arst_n_i  ( arst_n_i                ),
    .bus_req_i ( periph_req[PeriphTimer] ),
    .bus_rsp_o ( periph_rsp[PeriphTimer] ),
    .irq_o     ( timer_irq               )
  );

endmodule

//--- test/periph_checker.sv
// ----------------------------------------------------------------------
// Response and pin checker
// Queues expectations on accepted requests and compares responses
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module periph_checker import periph_pkg::*; (
  input  logic        clk_i,
  input  bus_req_t    bus_req_i,
  input  bus_rsp_t    bus_rsp_i,
  input  logic [31:0] exp_rdata_i,
  input  logic        exp_err_i,
  input  logic        exp_rd_i,
  input  logic        pin_chk_i,
  input  logic [2:0]  pin_sel_i,
  input  logic [31:0] pin_mask_i,
  input  logic [31:0] pin_exp_i,
  input  logic        fetch_enable_i,
  input  logic [31:0] boot_addr_i,
  input  logic [15:0] gpio_out_i,
  input  logic [15:0] gpio_out_en_i,
  input  logic [15:0] gpio_in_sync_i,
  input  logic [15:0] irq_i,
  output int          errors_o,
  output int          checks_o,
  output int          pending_o
);

  typedef struct packed {
    logic        rd;
    logic [31:0] rdata;
    logic        err;
  } expect_t;

  expect_t exp_q[$];
  logic pin_due = 1'b0;
  logic [2:0] sel_q;
  logic [31:0] mask_q, pexp_q;

  initial begin
    errors_o = 0;
    checks_o = 0;
  end

  assign pending_o = exp_q.size() + int'(pin_due);

  // Requests and pin strobes are stable at the rising edge
  always @(posedge clk_i) begin
    // Grant follows the request in the same cycle
    if (bus_rsp_i.gnt != bus_req_i.req) begin
      $display("mismatch at %0t: gnt exp %0b got %0b", $time, bus_req_i.req, bus_rsp_i.gnt);
      errors_o++;
    end
    if (bus_req_i.req && bus_rsp_i.gnt) begin
      exp_q.push_back('{exp_rd_i, exp_rdata_i, exp_err_i});
    end
    if (pin_chk_i) begin
      pin_due <= 1'b1;
      sel_q <= pin_sel_i;
      mask_q <= pin_mask_i;
      pexp_q <= pin_exp_i;
    end
  end

  // Responses and outputs settle after the rising edge
  always @(negedge clk_i) begin
    expect_t e;
    logic [31:0] got;
    string name;
    if (bus_rsp_i.rvalid && exp_q.size() == 0) begin
      $display("error at %0t: response arrived with no request pending", $time);
      errors_o++;
    end else if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      checks_o++;
      if (!bus_rsp_i.rvalid) begin
        $display("error at %0t: no response one cycle after the request", $time);
        errors_o++;
      end else if (bus_rsp_i.err != e.err) begin
        $display("mismatch at %0t: err exp %0b got %0b", $time, e.err, bus_rsp_i.err);
        errors_o++;
      end else if (e.rd && bus_rsp_i.rdata != e.rdata) begin
        $display("mismatch at %0t: rdata exp %h got %h", $time, e.rdata, bus_rsp_i.rdata);
        errors_o++;
      end
    end
    if (pin_due) begin
      pin_due <= 1'b0;
      checks_o++;
      case (sel_q)
        3'd0:    got = {31'b0, fetch_enable_i};
        3'd1:    got = boot_addr_i;
        3'd2:    got = {16'b0, gpio_out_i};
        3'd3:    got = {16'b0, gpio_out_en_i};
        3'd4:    got = {16'b0, irq_i};
        default: got = {16'b0, gpio_in_sync_i};
      endcase
      case (sel_q)
        3'd0:    name = "fetch_enable_o";
        3'd1:    name = "boot_addr_o";
        3'd2:    name = "gpio_o";
        3'd3:    name = "gpio_out_en_o";
        3'd4:    name = "irq_o";
        default: name = "gpio_in_sync_o";
      endcase
      if ((got & mask_q) != pexp_q) begin
        $display("mismatch at %0t: %s exp %h got %h", $time, name, pexp_q, got & mask_q);
        errors_o++;
      end
    end
  end

endmodule

//--- test/tb_periph_domain.sv
// ----------------------------------------------------------------------
// Peripheral domain testbench
// Clock, reset and a stimulus table applied row by row
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_periph_domain import periph_pkg::*; ();

  localparam logic [1:0] KindBus  = 2'd0;
  localparam logic [1:0] KindPin  = 2'd1;
  localparam logic [1:0] KindWait = 2'd2;
  localparam int unsigned WaitLimit = 60;

  // Pin column: gpio in bits 15:0, fetch pin in 16, external irqs in 20:17
  typedef struct packed {
    logic [7:0]  id;
    logic [1:0]  kind;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [20:0] pins;
    logic [31:0] exp;
    logic        err;
  } row_t;

  logic clk = 1'b0;
  logic arst_n;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic fetch_en, fetch_enable;
  logic [31:0] boot_addr;
  logic [15:0] gpio_in, gpio_out, gpio_oe, gpio_sync;
  logic [3:0] ext_irq;
  logic [15:0] irq;
  logic [31:0] exp_rdata;
  logic exp_err, exp_rd, pin_chk;
  logic [2:0] pin_sel;
  logic [31:0] pin_mask, pin_exp;
  logic timed_out;
  int errors, checks, pending;

  row_t stim_q[$];

  always #10 clk = ~clk;

  periph_domain #(.GpioCount(16)) DUT (
    .clk_i(clk), .arst_n_i(arst_n), .bus_req_i(bus_req), .bus_rsp_o(bus_rsp),
    .fetch_en_i(fetch_en), .fetch_enable_o(fetch_enable), .boot_addr_o(boot_addr),
    .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_out_en_o(gpio_oe),
    .gpio_in_sync_o(gpio_sync), .ext_irq_i(ext_irq), .irq_o(irq)
  );

  periph_checker i_checker (
    .clk_i(clk), .bus_req_i(bus_req), .bus_rsp_i(bus_rsp),
    .exp_rdata_i(exp_rdata), .exp_err_i(exp_err), .exp_rd_i(exp_rd),
    .pin_chk_i(pin_chk), .pin_sel_i(pin_sel), .pin_mask_i(pin_mask), .pin_exp_i(pin_exp),
    .fetch_enable_i(fetch_enable), .boot_addr_i(boot_addr), .gpio_out_i(gpio_out),
    .gpio_out_en_i(gpio_oe), .gpio_in_sync_i(gpio_sync), .irq_i(irq),
    .errors_o(errors), .checks_o(checks), .pending_o(pending)
  );

  function automatic logic [20:0] pins(input logic [15:0] g, input logic f,
                                       input logic [3:0] e);
    return {e, f, g};
  endfunction

  function automatic logic [31:0] observe_pin(input logic [2:0] sel);
    case (sel)
      3'd0:    return {31'b0, fetch_enable};
      3'd1:    return boot_addr;
      3'd2:    return {16'b0, gpio_out};
      3'd3:    return {16'b0, gpio_oe};
      3'd4:    return {16'b0, irq};
      default: return {16'b0, gpio_sync};
    endcase
  endfunction

  task automatic add_bus(input int id, input logic we, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] be,
                         input logic [20:0] p, input logic [31:0] exp, input logic err);
    stim_q.push_back('{id[7:0], KindBus, we, be, addr, wdata, p, exp, err});
  endtask

  // Pin rows reuse addr as the output select and wdata as the mask
  task automatic add_pin(input int id, input logic [1:0] kind, input int sel,
                         input logic [31:0] mask, input logic [31:0] exp,
                         input logic [20:0] p);
    stim_q.push_back('{id[7:0], kind, 1'b0, 4'h0, 32'(sel), mask, p, exp, 1'b0});
  endtask

  // Stops the table, the run then ends as a failure
  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    @(posedge clk);
    while (pending != 0 && !timed_out) begin
      if (n == WaitLimit) begin
        report_timeout("responses never arrived");
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic build_table();
    logic [31:0] r1, r2, merged;
    r1 = $urandom();
    r2 = $urandom();
    merged = {r1[31:24], r2[23:16], r1[15:8], r2[7:0]};
    // SoC control
    add_bus(1, 0, SocCtrlBase, 0, 4'hF, pins(0, 0, 0), 32'h1000_0000, 0);
    add_pin(1, KindPin, 1, 32'hFFFF_FFFF, 32'h1000_0000, pins(0, 0, 0));
    add_bus(1, 1, SocCtrlBase, r1, 4'hF, pins(0, 0, 0), 0, 0);
    add_bus(1, 0, SocCtrlBase, 0, 4'hF, pins(0, 0, 0), r1, 0);
    add_bus(1, 1, SocCtrlBase, r2, 4'b0101, pins(0, 0, 0), 0, 0);
    add_bus(1, 0, SocCtrlBase, 0, 4'h0, pins(0, 0, 0), merged, 0);
    add_pin(1, KindPin, 1, 32'hFFFF_FFFF, merged, pins(0, 0, 0));
    add_pin(1, KindPin, 0, 1, 0, pins(0, 0, 0));
    add_pin(1, KindPin, 0, 1, 1, pins(0, 1, 0));
    add_bus(1, 1, SocCtrlBase + 4, 1, 4'h1, pins(0, 0, 0), 0, 0);
    add_pin(1, KindPin, 0, 1, 1, pins(0, 0, 0));
    add_bus(1, 0, SocCtrlBase + 4, 0, 4'hF, pins(0, 0, 0), 1, 0);
    add_bus(1, 1, SocCtrlBase + 4, 0, 4'hF, pins(0, 0, 0), 0, 0);
    add_pin(1, KindPin, 0, 1, 0, pins(0, 0, 0));
    // Unmapped addresses
    add_bus(2, 0, 32'h0300_1000, 0, 4'hF, pins(0, 0, 0), 32'hBADC_AB1E, 1);
    add_bus(2, 1, 32'h2000_0000, r1, 4'hF, pins(0, 0, 0), 0, 1);
    add_bus(2, 0, SocCtrlBase, 0, 4'hF, pins(0, 0, 0), merged, 0);
    // GPIO output and input
    add_bus(3, 1, GpioBase, 32'h00FF, 4'hF, pins(0, 0, 0), 0, 0);
    add_bus(3, 1, GpioBase + 4, 32'h00A5, 4'hF, pins(0, 0, 0), 0, 0);
    add_pin(3, KindPin, 3, 32'hFFFF, 32'h00FF, pins(0, 0, 0));
    add_pin(3, KindPin, 2, 32'hFFFF, 32'h00A5, pins(0, 0, 0));
    add_pin(3, KindWait, 5, 32'hFFFF, 32'h3C00, pins(16'h3C00, 0, 0));
    add_bus(3, 0, GpioBase + 8, 0, 4'hF, pins(16'h3C00, 0, 0), 32'h3C00, 0);
    // GPIO interrupt
    add_pin(4, KindWait, 5, 32'hFFFF, 0, pins(0, 0, 0));
    add_bus(4, 1, GpioBase + 12, 1, 4'hF, pins(0, 0, 0), 0, 0);
    add_pin(4, KindWait, 4, 2, 2, pins(1, 0, 0));
    add_bus(4, 0, GpioBase + 16, 0, 4'hF, pins(1, 0, 0), 1, 0);
    add_bus(4, 1, GpioBase + 16, 1, 4'hF, pins(1, 0, 0), 0, 0);
    add_pin(4, KindPin, 4, 2, 0, pins(1, 0, 0));
    add_bus(4, 0, GpioBase + 16, 0, 4'hF, pins(1, 0, 0), 0, 0);
    // Timer
    add_bus(5, 1, TimerBase + 8, 5, 4'hF, pins(1, 0, 0), 0, 0);
    add_bus(5, 1, TimerBase, 1, 4'hF, pins(1, 0, 0), 0, 0);
    add_pin(5, KindWait, 4, 1, 1, pins(1, 0, 0));
    add_bus(5, 0, TimerBase + 12, 0, 4'hF, pins(1, 0, 0), 1, 0);
    add_bus(5, 1, TimerBase, 0, 4'hF, pins(1, 0, 0), 0, 0);
    add_bus(5, 1, TimerBase + 12, 1, 4'hF, pins(1, 0, 0), 0, 0);
    add_pin(5, KindPin, 4, 1, 0, pins(1, 0, 0));
    // Back-to-back reads and external interrupts
    add_pin(6, KindPin, 4, 32'hFFFF, 32'h0028, pins(1, 0, 4'hA));
    add_pin(6, KindPin, 4, 32'hFFFF, 32'h0014, pins(1, 0, 4'h5));
    add_bus(6, 0, SocCtrlBase, 0, 4'hF, pins(1, 0, 0), merged, 0);
    add_bus(6, 0, GpioBase, 0, 4'hF, pins(1, 0, 0), 32'h00FF, 0);
    add_bus(6, 0, TimerBase + 8, 0, 4'hF, pins(1, 0, 0), 5, 0);
    add_bus(6, 0, 32'h0400_0000, 0, 4'hF, pins(1, 0, 0), 32'hBADC_AB1E, 1);
    add_bus(6, 0, SocCtrlBase + 4, 0, 4'hF, pins(1, 0, 0), 0, 0);
    add_bus(6, 0, GpioBase + 8, 0, 4'hF, pins(1, 0, 0), 1, 0);
  endtask

  initial begin
    row_t r;
    int n, err_before, n_tests, n_failed;
    void'($urandom(32'h89e6fde0));
    arst_n = 1'b0;
    bus_req = '0;
    {fetch_en, gpio_in, ext_irq} = '0;
    {exp_rdata, exp_err, exp_rd, pin_chk, pin_sel, pin_mask, pin_exp} = '0;
    timed_out = 1'b0;
    n_tests = 0;
    n_failed = 0;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    err_before = 0;
    for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
      r = stim_q[i];
      @(negedge clk);
      {ext_irq, fetch_en, gpio_in} = r.pins;
      bus_req = '0;
      pin_chk = 1'b0;
      case (r.kind)
        KindBus: begin
          bus_req = '{req: 1'b1, we: r.we, be: r.be, addr: r.addr, wdata: r.wdata};
          exp_rdata = r.exp;
          exp_err = r.err;
          exp_rd = !r.we;
        end
        KindPin: begin
          pin_chk = 1'b1;
          pin_sel = r.addr[2:0];
          pin_mask = r.wdata;
          pin_exp = r.exp;
          // Hold the pins one more cycle while the checker compares
          @(negedge clk);
          pin_chk = 1'b0;
        end
        default: begin
          n = 0;
          while ((observe_pin(r.addr[2:0]) & r.wdata) != r.exp && !timed_out) begin
            if (n == WaitLimit) begin
              report_timeout($sformatf("test %0d pin wait", r.id));
            end else begin
              @(negedge clk);
              n++;
            end
          end
        end
      endcase
      if (!timed_out && (i == stim_q.size() - 1 || stim_q[i+1].id != r.id)) begin
        @(negedge clk);
        bus_req = '0;
        wait_drained();
        n_tests++;
        if (errors != err_before) n_failed++;
        $display("test %0d: %s, %0d errors", r.id,
                 (errors == err_before) ? "ok" : "FAIL", errors - err_before);
        err_before = errors;
      end
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, checks, errors);
    if (!timed_out && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- periph_domain.f
common/periph_pkg.sv
source/periph_demux.sv
soc_ctrl/soc_ctrl_regs.sv
gpio/gpio_ctrl.sv
timer/timer_ctrl.sv
source/periph_domain.sv
test/periph_checker.sv
test/tb_periph_domain.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f periph_domain.f \
		--top-module tb_periph_domain -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
